// File: rtl/sdramPkg.sv
//////////////////////////////////////////////////////////////////////
// shared definitions for the sdram init and refresh controller
//   command codes and the command word union
//   address, bank and timer widths
//   init and refresh timing, mode register value
//   sequencer state codes
//////////////////////////////////////////////////////////////////////

package sdramPkg;

	//////////////////////////////////////////////////////////////////////
	// command word
	//////////////////////////////////////////////////////////////////////

	// five pin command, msb first as cke, cs, ras, cas, we
	typedef union packed {
		logic [4:0] code;		// whole encoded command
		struct packed {
			logic cke;		// clock enable, active high
			logic csL;		// chip select
			logic rasL;
			logic casL;
			logic weL;
		} pins;
	} sdramCmd;

	localparam logic [4:0] cmdPoweringUp      = 5'b00000;	// cke and cs low during power up
	localparam logic [4:0] cmdNop             = 5'b10111;
	localparam logic [4:0] cmdPrechargeAll    = 5'b10010;	// needs addr bit 10 high
	localparam logic [4:0] cmdAutoRefresh     = 5'b10001;
	localparam logic [4:0] cmdModeRegisterSet = 5'b10000;	// mode value on addr, bank 0

	//////////////////////////////////////////////////////////////////////
	// widths
	//////////////////////////////////////////////////////////////////////

	localparam int timerWidth     = 16;
	localparam int sdramAddrWidth = 13;	// 8192 rows
	localparam int sdramBankWidth = 2;	// 4 banks
	localparam int prechargeAllBit = 10;	// a10 selects all banks on precharge

	//////////////////////////////////////////////////////////////////////
	// timing and mode
	//////////////////////////////////////////////////////////////////////

	// short power up hold for simulation, silicon wants about 100us
	localparam logic [timerWidth-1:0] powerUpCycles = 16'd20;
	localparam int initRefreshCount     = 10;	// auto refreshes during init
	localparam int nopGapCycles         = 4;	// nops after each refresh and after mrs
	localparam logic [timerWidth-1:0] refreshPeriod = 16'd400;	// precharge to precharge
	localparam int refreshEpisodeCycles = 7;	// precharge, nop, refresh, nop gap

	// burst length 1, sequential, cas latency 2, single location write
	localparam logic [sdramAddrWidth-1:0] modeRegisterValue = 13'h220;

	//////////////////////////////////////////////////////////////////////
	// sequencer states
	//////////////////////////////////////////////////////////////////////

	localparam int stateWidth = 4;

	localparam logic [stateWidth-1:0] initialising     = 4'd0;
	localparam logic [stateWidth-1:0] waitPowerUp      = 4'd1;
	localparam logic [stateWidth-1:0] firstNop         = 4'd2;
	localparam logic [stateWidth-1:0] prechargeAll     = 4'd3;
	localparam logic [stateWidth-1:0] initRefresh      = 4'd4;
	localparam logic [stateWidth-1:0] initNopGap       = 4'd5;
	localparam logic [stateWidth-1:0] modeSet          = 4'd6;
	localparam logic [stateWidth-1:0] modeNopGap       = 4'd7;
	localparam logic [stateWidth-1:0] loadRefreshTimer = 4'd8;
	localparam logic [stateWidth-1:0] idle             = 4'd9;
	localparam logic [stateWidth-1:0] refreshPrecharge = 4'd10;
	localparam logic [stateWidth-1:0] refreshNop       = 4'd11;
	localparam logic [stateWidth-1:0] refreshRefresh   = 4'd12;
	localparam logic [stateWidth-1:0] refreshNopGap    = 4'd13;

endpackage

// File: rtl/countdownTimer.sv
//////////////////////////////////////////////////////////////////////
// countdownTimer
//   loadable down counter that stops at zero
//   done flag while the count is zero
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module countdownTimer
	import sdramPkg::*;
(
	input  logic                  Clock,
	input  logic                  Reset_L,
	input  logic                  load,		// preload on this edge
	input  logic [timerWidth-1:0] loadValue,
	output logic                  done		// high while count is zero
);

	logic [timerWidth-1:0] count;

	// load wins over counting, count holds once it hits zero
	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			count <= '0;
		end
		else if (load)
		begin
			count <= loadValue;
		end
		else if (count != '0)
		begin
			count <= count - 1'b1;
		end
	end

	// done rises loadValue cycles after the load edge
	assign done = (count == '0);

endmodule

// File: rtl/sdramSequencer.sv
//////////////////////////////////////////////////////////////////////
// sdramSequencer
//   FSM for power up, init and periodic refresh
//   refresh counter and nop gap counter
//   timer load control for the power up and refresh timers
//   registered sdram pins and cpu reset out
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sdramSequencer
	import sdramPkg::*;
(
	input  logic                      Clock,
	input  logic                      Reset_L,
	// power up timer
	output logic                      powerUpLoad,
	output logic [timerWidth-1:0]     powerUpValue,
	input  logic                      powerUpDone,
	// refresh timer
	output logic                      refreshLoad,
	output logic [timerWidth-1:0]     refreshValue,
	input  logic                      refreshDone,
	// sdram pins
	output logic                      SDram_CKE_H,
	output logic                      SDram_CS_L,
	output logic                      SDram_RAS_L,
	output logic                      SDram_CAS_L,
	output logic                      SDram_WE_L,
	output logic [sdramAddrWidth-1:0] SDram_Addr,
	output logic [sdramBankWidth-1:0] SDram_BA,
	output logic                      ResetOut_L		// held low until init is done
);

	logic [stateWidth-1:0]     state;
	logic [stateWidth-1:0]     nextState;
	sdramCmd                   cmd;			// command for the pins next cycle
	logic [sdramAddrWidth-1:0] addr;
	logic                      resetOutNext;

	logic [$clog2(nopGapCycles)-1:0]       gapCount;
	logic [$clog2(initRefreshCount+1)-1:0] refreshCount;
	logic                                  inGap;
	logic                                  gapLast;

	assign inGap   = (state == initNopGap) || (state == modeNopGap) || (state == refreshNopGap);
	assign gapLast = (gapCount == $bits(gapCount)'(nopGapCycles - 1));

	// initialising and waitPowerUp each give one powering up cycle on top of the count
	assign powerUpValue = powerUpCycles - timerWidth'(2);

	// done shows on the pins two cycles later, via idle and refreshPrecharge
	// after init the timer starts with the first idle nop, in an episode
	// it is reloaded on the third gap nop
	assign refreshValue = (state == loadRefreshTimer) ? refreshPeriod - timerWidth'(2)
		: refreshPeriod - timerWidth'(refreshEpisodeCycles);

	//////////////////////////////////////////////////////////////////////
	// state and counters
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			state <= initialising;
		end
		else
		begin
			state <= nextState;
		end
	end

	// gap counter restarts on each state entry, counts nops in a gap
	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			gapCount <= '0;
		end
		else if (nextState != state)
		begin
			gapCount <= '0;
		end
		else if (inGap)
		begin
			gapCount <= gapCount + 1'b1;
		end
	end

	// counts init refreshes, cleared as prechargeAll is entered
	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			refreshCount <= '0;
		end
		else if ((nextState == prechargeAll) && (state != prechargeAll))
		begin
			refreshCount <= '0;
		end
		else if (state == initRefresh)
		begin
			refreshCount <= refreshCount + 1'b1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// next state and command
	//////////////////////////////////////////////////////////////////////

	always_comb
	begin
		nextState    = state;
		cmd.code     = cmdNop;		// nop unless a state says otherwise
		addr         = '0;
		resetOutNext = 1'b0;
		powerUpLoad  = 1'b0;
		refreshLoad  = 1'b0;

		case (state)
			initialising:
			begin
				cmd.code    = cmdPoweringUp;
				powerUpLoad = 1'b1;		// start the power up hold
				nextState   = waitPowerUp;
			end
			waitPowerUp:
			begin
				cmd.code = cmdPoweringUp;
				if (powerUpDone)
				begin
					nextState = firstNop;
				end
			end
			firstNop:
			begin
				nextState = prechargeAll;	// cke and cs come up with this nop
			end
			prechargeAll:
			begin
				cmd.code              = cmdPrechargeAll;
				addr[prechargeAllBit] = 1'b1;
				nextState             = initRefresh;
			end
			initRefresh:
			begin
				cmd.code  = cmdAutoRefresh;
				nextState = initNopGap;
			end
			initNopGap:
			begin
				if (gapLast)
				begin
					// last refresh of init is followed by the mode set
					if (refreshCount == $bits(refreshCount)'(initRefreshCount))
					begin
						nextState = modeSet;
					end
					else
					begin
						nextState = initRefresh;
					end
				end
			end
			modeSet:
			begin
				cmd.code  = cmdModeRegisterSet;
				addr      = modeRegisterValue;
				nextState = modeNopGap;		// bank stays 0
			end
			modeNopGap:
			begin
				if (gapLast)
				begin
					nextState = loadRefreshTimer;
				end
			end
			loadRefreshTimer:
			begin
				resetOutNext = 1'b1;		// cpu leaves reset here
				refreshLoad  = 1'b1;
				nextState    = idle;
			end
			idle:
			begin
				resetOutNext = 1'b1;
				if (refreshDone)
				begin
					nextState = refreshPrecharge;
				end
			end
			refreshPrecharge:
			begin
				resetOutNext          = 1'b1;
				cmd.code              = cmdPrechargeAll;
				addr[prechargeAllBit] = 1'b1;
				nextState             = refreshNop;
			end
			refreshNop:
			begin
				resetOutNext = 1'b1;
				nextState    = refreshRefresh;
			end
			refreshRefresh:
			begin
				resetOutNext = 1'b1;
				cmd.code     = cmdAutoRefresh;
				nextState    = refreshNopGap;
			end
			refreshNopGap:
			begin
				resetOutNext = 1'b1;
				// reload one nop before the gap ends
				if (gapCount == $bits(gapCount)'(nopGapCycles - 2))
				begin
					refreshLoad = 1'b1;
				end
				if (gapLast)
				begin
					nextState = idle;
				end
			end
			default:
			begin
				cmd.code  = cmdPoweringUp;	// unused codes restart init
				nextState = initialising;
			end
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// pin registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge Clock or negedge Reset_L)
	begin
		if (!Reset_L)
		begin
			{SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L, SDram_WE_L} <= cmdPoweringUp;
			SDram_Addr <= '0;
			SDram_BA   <= '0;
			ResetOut_L <= 1'b0;
		end
		else
		begin
			SDram_CKE_H <= cmd.pins.cke;
			SDram_CS_L  <= cmd.pins.csL;
			SDram_RAS_L <= cmd.pins.rasL;
			SDram_CAS_L <= cmd.pins.casL;
			SDram_WE_L  <= cmd.pins.weL;
			SDram_Addr  <= addr;
			SDram_BA    <= '0;		// every command here uses bank 0
			ResetOut_L  <= resetOutNext;
		end
	end

endmodule

// File: rtl/sdramController.sv
//////////////////////////////////////////////////////////////////////
// sdramController
//   top level of the sdram init and refresh controller
//   sequencer plus power up and refresh timers
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sdramController
	import sdramPkg::*;
(
	input  logic                      Clock,
	input  logic                      Reset_L,
	output logic                      SDram_CKE_H,
	output logic                      SDram_CS_L,
	output logic                      SDram_RAS_L,
	output logic                      SDram_CAS_L,
	output logic                      SDram_WE_L,
	output logic [sdramAddrWidth-1:0] SDram_Addr,
	output logic [sdramBankWidth-1:0] SDram_BA,
	output logic                      ResetOut_L	// reset to the cpu
);

	logic                  powerUpLoad;
	logic [timerWidth-1:0] powerUpValue;
	logic                  powerUpDone;
	logic                  refreshLoad;
	logic [timerWidth-1:0] refreshValue;
	logic                  refreshDone;

	sdramSequencer sdramSequencer_i (
		.Clock        (Clock),
		.Reset_L      (Reset_L),
		.powerUpLoad  (powerUpLoad),
		.powerUpValue (powerUpValue),
		.powerUpDone  (powerUpDone),
		.refreshLoad  (refreshLoad),
		.refreshValue (refreshValue),
		.refreshDone  (refreshDone),
		.SDram_CKE_H  (SDram_CKE_H),
		.SDram_CS_L   (SDram_CS_L),
		.SDram_RAS_L  (SDram_RAS_L),
		.SDram_CAS_L  (SDram_CAS_L),
		.SDram_WE_L   (SDram_WE_L),
		.SDram_Addr   (SDram_Addr),
		.SDram_BA     (SDram_BA),
		.ResetOut_L   (ResetOut_L)
	);

	// hold of cke and cs after reset
	countdownTimer powerUpTimer (
		.Clock     (Clock),
		.Reset_L   (Reset_L),
		.load      (powerUpLoad),
		.loadValue (powerUpValue),
		.done      (powerUpDone)
	);

	// spacing of the periodic refresh episodes
	countdownTimer refreshTimer (
		.Clock     (Clock),
		.Reset_L   (Reset_L),
		.load      (refreshLoad),
		.loadValue (refreshValue),
		.done      (refreshDone)
	);

endmodule

// File: testbench/sdramControllerTb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the sdram init and refresh controller
//   clock, reset and seeded random reset pulses
//   reference model of the pin command sequence
//   per cycle pin checks, refresh spacing, closing summary
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module sdramControllerTb
	import sdramPkg::*;
();

	// jedec truth table, cke cs ras cas we
	localparam logic [4:0] pinsPowerUp   = 5'b00000;
	localparam logic [4:0] pinsNop       = 5'b10111;
	localparam logic [4:0] pinsPrecharge = 5'b10010;
	localparam logic [4:0] pinsRefresh   = 5'b10001;
	localparam logic [4:0] pinsModeSet   = 5'b10000;
	// a9 single write, a6..a4 cas 2, a3 sequential, a2..a0 burst 1
	localparam logic [12:0] modeWord = {3'b000, 1'b1, 2'b00, 3'b010, 1'b0, 3'b000};

	// sequence positions, counted in rising edges after reset release
	localparam int powerUpLength      = int'(powerUpCycles);
	localparam int refreshLength      = int'(refreshPeriod);
	localparam int initPrechargeCycle = powerUpLength + 2;	// one nop before it
	localparam int firstRefreshCycle  = initPrechargeCycle + 1;
	localparam int modeSetCycle       = firstRefreshCycle + initRefreshCount * (nopGapCycles + 1);
	localparam int releaseCycle       = modeSetCycle + nopGapCycles + 1;
	localparam int firstEpisodeCycle  = releaseCycle + refreshLength;

	logic                      Clock = 1'b0;
	logic                      Reset_L;
	logic                      SDram_CKE_H;
	logic                      SDram_CS_L;
	logic                      SDram_RAS_L;
	logic                      SDram_CAS_L;
	logic                      SDram_WE_L;
	logic [sdramAddrWidth-1:0] SDram_Addr;
	logic [sdramBankWidth-1:0] SDram_BA;
	logic                      ResetOut_L;

	integer seed;
	int     cycle = 0;		// edges since reset went high
	int     errorCount = 0;
	int     checkCount = 0;
	int     episodeCount = 0;	// idle phase precharges since reset
	int     lastPrechargeCycle = 0;
	int     riseCycle = 0;
	int     riseCount = 0;
	int     spacing;
	logic   prevResetOut = 1'b0;
	logic   timedOut = 1'b0;

	// model outputs for the current cycle
	logic [4:0]                expPins;
	logic [sdramAddrWidth-1:0] expAddr;
	logic [sdramBankWidth-1:0] expBank;
	logic                      expResetOut;

	sdramController sdramController_i (
		.Clock       (Clock),
		.Reset_L     (Reset_L),
		.SDram_CKE_H (SDram_CKE_H),
		.SDram_CS_L  (SDram_CS_L),
		.SDram_RAS_L (SDram_RAS_L),
		.SDram_CAS_L (SDram_CAS_L),
		.SDram_WE_L  (SDram_WE_L),
		.SDram_Addr  (SDram_Addr),
		.SDram_BA    (SDram_BA),
		.ResetOut_L  (ResetOut_L)
	);

	always #5 Clock = ~Clock;		// 10 ns period

	always @(posedge Clock)
	begin
		if (!Reset_L)
			cycle <= 0;		// model restarts with every reset
		else
			cycle <= cycle + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// reference model and reporting
	//////////////////////////////////////////////////////////////////////

	// pins expected after rising edge k, k of 0 is the reset state
	task automatic predictPins(input int k);
		int slot;
		expPins     = pinsNop;		// nop unless the sequence says otherwise
		expAddr     = '0;
		expBank     = '0;
		expResetOut = (k >= releaseCycle);
		if (k <= powerUpLength)
			expPins = pinsPowerUp;
		else if (k == initPrechargeCycle)
		begin
			expPins                  = pinsPrecharge;
			expAddr[prechargeAllBit] = 1'b1;
		end
		else if ((k >= firstRefreshCycle) && (k < modeSetCycle))
		begin
			slot = (k - firstRefreshCycle) % (nopGapCycles + 1);
			if (slot == 0)
				expPins = pinsRefresh;		// then the nop gap
		end
		else if (k == modeSetCycle)
		begin
			expPins = pinsModeSet;
			expAddr = modeWord;
		end
		else if (k >= firstEpisodeCycle)
		begin
			slot = (k - firstEpisodeCycle) % refreshLength;
			if (slot == 0)
			begin
				expPins                  = pinsPrecharge;
				expAddr[prechargeAllBit] = 1'b1;
			end
			else if (slot == 2)
				expPins = pinsRefresh;
		end
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		errorCount++;
		$display("Mismatch at %0t ns: %s expected %0h got %0h", $time, name, expected, actual);
	endtask

	task automatic noteTimeout(input string what);
		errorCount++;
		timedOut = 1'b1;		// later steps are skipped
		$display("Timeout at %0t ns: %s", $time, what);
	endtask

	//////////////////////////////////////////////////////////////////////
	// checks, sampled on the falling edge where the pins are stable
	//////////////////////////////////////////////////////////////////////

	always @(negedge Clock)
	begin
		predictPins(Reset_L ? cycle : 0);
		checkCount++;
		if (SDram_CKE_H !== expPins[4])
			reportMismatch("SDram_CKE_H", 32'(expPins[4]), 32'(SDram_CKE_H));
		if (SDram_CS_L !== expPins[3])
			reportMismatch("SDram_CS_L", 32'(expPins[3]), 32'(SDram_CS_L));
		if (SDram_RAS_L !== expPins[2])
			reportMismatch("SDram_RAS_L", 32'(expPins[2]), 32'(SDram_RAS_L));
		if (SDram_CAS_L !== expPins[1])
			reportMismatch("SDram_CAS_L", 32'(expPins[1]), 32'(SDram_CAS_L));
		if (SDram_WE_L !== expPins[0])
			reportMismatch("SDram_WE_L", 32'(expPins[0]), 32'(SDram_WE_L));
		if (SDram_Addr !== expAddr)
			reportMismatch("SDram_Addr", 32'(expAddr), 32'(SDram_Addr));
		if (SDram_BA !== expBank)
			reportMismatch("SDram_BA", 32'(expBank), 32'(SDram_BA));
		if (ResetOut_L !== expResetOut)
			reportMismatch("ResetOut_L", 32'(expResetOut), 32'(ResetOut_L));

		if (!Reset_L)
		begin
			riseCount    = 0;
			episodeCount = 0;
		end
		else
		begin
			if ((ResetOut_L === 1'b1) && (prevResetOut !== 1'b1))
			begin
				riseCount++;
				riseCycle = cycle;
				if (riseCount > 1)
				begin
					errorCount++;
					$display("ResetOut_L rose a second time at %0t ns with no reset between", $time);
				end
			end
			// idle phase precharge, measured against the actual rise or last precharge
			if ((ResetOut_L === 1'b1) && ({SDram_CKE_H, SDram_CS_L, SDram_RAS_L, SDram_CAS_L,
				SDram_WE_L} === pinsPrecharge))
			begin
				spacing = (episodeCount == 0) ? cycle - riseCycle : cycle - lastPrechargeCycle;
				if (spacing != refreshLength)
					reportMismatch("precharge spacing", 32'(refreshLength), 32'(spacing));
				episodeCount++;
				lastPrechargeCycle = cycle;
			end
		end
		prevResetOut = ResetOut_L;
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus, always 1 ns after a rising edge
	//////////////////////////////////////////////////////////////////////

	task automatic pulseReset(input int lowCycles);
		Reset_L = 1'b0;
		repeat (lowCycles) @(posedge Clock);
		#1;
		Reset_L = 1'b1;
	endtask

	// lands before ResetOut_L would rise
	task automatic pulseDuringInit();
		int delay;
		int lowCycles;
		delay     = 1 + int'({$random(seed)} % (releaseCycle - 1));
		lowCycles = 1 + int'({$random(seed)} % 3);
		if (!timedOut)
		begin
			repeat (delay) @(posedge Clock);
			#1;
			pulseReset(lowCycles);
		end
	endtask

	// waits for a refresh precharge, then hits one of the following episode cycles
	task automatic pulseDuringEpisode();
		int startCount;
		int waited;
		int offset;
		int lowCycles;
		startCount = episodeCount;
		waited     = 0;
		offset     = int'({$random(seed)} % 6);
		lowCycles  = 1 + int'({$random(seed)} % 3);
		if (!timedOut)
		begin
			while ((episodeCount == startCount) && (waited < releaseCycle + 2 * refreshLength))
			begin
				@(posedge Clock);
				waited++;
			end
			if (episodeCount == startCount)
				noteTimeout("no refresh precharge came before the reset pulse");
			else
			begin
				repeat (offset) @(posedge Clock);
				#1;
				pulseReset(lowCycles);
			end
		end
	endtask

	task automatic waitForEpisodes(input int target);
		int waited;
		waited = 0;
		if (!timedOut)
		begin
			while ((episodeCount < target) && (waited < releaseCycle + refreshLength * (target + 1)))
			begin
				@(posedge Clock);
				waited++;
			end
			if (episodeCount < target)
				noteTimeout("too few refresh episodes after initialisation");
		end
	endtask

	task automatic finishRun();
		$display("%0d cycles checked, %0d errors", checkCount, errorCount);
		if (errorCount == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	endtask

	initial
	begin
		seed    = 32'h7507cd58;
		Reset_L = 1'b0;
		repeat (2) @(posedge Clock);	// 2 cycle power on reset
		#1;
		Reset_L = 1'b1;
		pulseDuringInit();
		pulseDuringInit();
		waitForEpisodes(6);		// full init, then six refresh episodes
		pulseDuringEpisode();
		waitForEpisodes(2);		// restarted from power up
		pulseDuringEpisode();
		waitForEpisodes(1);
		finishRun();
	end

endmodule

// File: flist.f
rtl/sdramPkg.sv
rtl/countdownTimer.sv
rtl/sdramSequencer.sv
rtl/sdramController.sv
testbench/sdramControllerTb.sv

// File: run.sh
#!/bin/sh
# build and run the sdram controller testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module sdramControllerTb \
	--Mdir obj_dir -o simv -f flist.f

output=$(./obj_dir/simv)
echo "$output"

if echo "$output" | grep -q "ALL TESTS PASSED"; then
	exit 0
fi
exit 1
